// File: build.f
+incdir+.
fp_arith_pkg.sv
fp_mult_pipe.sv
fp_div_seq.sv
fp_result_merge.sv
fp_arith_unit.sv
tb_fp_arith_unit.sv

// File: fp_arith_pkg.sv
// operation select enum, default fixed-point format and divider step count helper
`default_nettype none

package fp_arith_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // operation select
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic {
    op_mul = 1'b0,  // pipelined multiplier.
    op_div = 1'b1   // sequential divider.
  } arith_op_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // default word format, 16.16
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int DEFAULT_WIDTH      = 32;  // total word width.
  localparam int DEFAULT_FRAC_WIDTH = 16;  // bits right of the binary point.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // divider sizing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // The restoring divider consumes one dividend bit per step. The dividend
  // is the operand shifted left by the fraction width, so it is
  // width + frac_width bits long.
  function automatic int div_iterations(
    input int width,
    input int frac_width
  );
    return width + frac_width;
  endfunction

endpackage

`default_nettype wire

// File: fp_arith_unit.sv
// fixed-point arithmetic unit top level with multiply and divide engines and result merge
`timescale 1ns/10ps
`default_nettype none

module fp_arith_unit import fp_arith_pkg::*; #(
  parameter int WIDTH      = DEFAULT_WIDTH,
  parameter int FRAC_WIDTH = DEFAULT_FRAC_WIDTH
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             start,
  input  arith_op_e        op,
  input  logic             is_signed,
  input  logic [WIDTH-1:0] left,
  input  logic [WIDTH-1:0] right,
  output logic [WIDTH-1:0] result,
  output arith_op_e        result_op,
  output logic             done,
  output logic             busy
);

  logic             mul_start;
  logic             div_start;
  logic             mul_valid;
  logic [WIDTH-1:0] mul_result;
  logic             div_valid;
  logic [WIDTH-1:0] div_result;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // start routing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign mul_start = start && (op == op_mul);
  assign div_start = start && (op == op_div);  // divider drops it while busy.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // engines
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  fp_mult_pipe #(
    .WIDTH      (WIDTH),
    .FRAC_WIDTH (FRAC_WIDTH)
  ) i_fp_mult_pipe (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (mul_start),
    .is_signed  (is_signed),
    .left       (left),
    .right      (right),
    .mul_valid  (mul_valid),
    .mul_result (mul_result)
  );

  fp_div_seq #(
    .WIDTH      (WIDTH),
    .FRAC_WIDTH (FRAC_WIDTH)
  ) i_fp_div_seq (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (div_start),
    .is_signed  (is_signed),
    .left       (left),
    .right      (right),
    .busy       (busy),
    .div_valid  (div_valid),
    .div_result (div_result)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // result merge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  fp_result_merge #(
    .WIDTH      (WIDTH)
  ) i_fp_result_merge (
    .clk        (clk),
    .rst_n      (rst_n),
    .mul_valid  (mul_valid),
    .mul_result (mul_result),
    .div_valid  (div_valid),
    .div_result (div_result),
    .result     (result),
    .result_op  (result_op),
    .done       (done)
  );

endmodule

`default_nettype wire

// File: fp_div_seq.sv
// sequential signed/unsigned fixed-point restoring divider with sign handling
`timescale 1ns/10ps
`default_nettype none

module fp_div_seq import fp_arith_pkg::*; #(
  parameter int WIDTH      = DEFAULT_WIDTH,
  parameter int FRAC_WIDTH = DEFAULT_FRAC_WIDTH
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             start,
  input  logic             is_signed,
  input  logic [WIDTH-1:0] left,
  input  logic [WIDTH-1:0] right,
  output logic             busy,
  output logic             div_valid,
  output logic [WIDTH-1:0] div_result
);

  localparam int ITERS = div_iterations(WIDTH, FRAC_WIDTH);
  localparam int CNT_W = $clog2(ITERS);

  logic             accept;
  logic             last_step;
  logic [CNT_W-1:0] step_q;

  // operand magnitudes and sign of the quotient.
  logic [WIDTH-1:0] left_mag;
  logic [WIDTH-1:0] right_mag;
  logic             negate;

  // working registers.
  logic [ITERS-1:0] quo_q;   // dividend bits shift out, quotient bits in.
  logic [WIDTH-1:0] rem_q;   // partial remainder, always below the divisor.
  logic [WIDTH-1:0] dvs_q;   // divisor magnitude.
  logic             neg_q;

  // one restoring step.
  logic [WIDTH:0]   rem_shift;
  logic [WIDTH:0]   rem_diff;
  logic             fits;
  logic [WIDTH-1:0] rem_next;
  logic [ITERS-1:0] quo_next;
  logic [WIDTH-1:0] quo_low;

  assign accept    = start && !busy;  // a start during busy is dropped.
  assign last_step = (step_q == CNT_W'(ITERS - 1));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sign handling
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // the most negative value negates to itself, which read unsigned is
  // exactly its magnitude.
  assign left_mag  = (is_signed && left[WIDTH-1])  ? -left  : left;
  assign right_mag = (is_signed && right[WIDTH-1]) ? -right : right;
  assign negate    = is_signed && (left[WIDTH-1] ^ right[WIDTH-1]);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // restoring step
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // a zero divisor always fits, so every quotient bit comes out one.
  assign rem_shift = {rem_q, quo_q[ITERS-1]};
  assign rem_diff  = rem_shift - {1'b0, dvs_q};
  assign fits      = (rem_shift >= {1'b0, dvs_q});
  assign rem_next  = fits ? rem_diff[WIDTH-1:0] : rem_shift[WIDTH-1:0];
  assign quo_next  = {quo_q[ITERS-2:0], fits};
  assign quo_low   = quo_next[WIDTH-1:0];  // upper quotient bits are dropped.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      div_valid <= 1'b0;
      step_q    <= '0;
    end else begin
      div_valid <= 1'b0;
      if (accept) begin
        busy   <= 1'b1;
        step_q <= '0;
      end else if (busy) begin
        step_q <= step_q + 1'b1;
        if (last_step) begin
          busy      <= 1'b0;
          div_valid <= 1'b1;
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // datapath
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (accept) begin
      quo_q <= ITERS'(left_mag) << FRAC_WIDTH;  // magnitude scaled by 2^frac.
      rem_q <= '0;
      dvs_q <= right_mag;
      neg_q <= negate;
    end else if (busy) begin
      quo_q <= quo_next;
      rem_q <= rem_next;
    end
  end

  always_ff @(posedge clk) begin
    if (busy && last_step) begin
      div_result <= neg_q ? -quo_low : quo_low;
    end
  end

endmodule

`default_nettype wire

// File: fp_mult_pipe.sv
// three-stage pipelined signed/unsigned fixed-point multiplier
`timescale 1ns/10ps
`default_nettype none

module fp_mult_pipe import fp_arith_pkg::*; #(
  parameter int WIDTH      = DEFAULT_WIDTH,
  parameter int FRAC_WIDTH = DEFAULT_FRAC_WIDTH
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             start,
  input  logic             is_signed,
  input  logic [WIDTH-1:0] left,
  input  logic [WIDTH-1:0] right,
  output logic             mul_valid,
  output logic [WIDTH-1:0] mul_result
);

  localparam int PROD_WIDTH = 2 * WIDTH;

  // stage one, registered operands.
  logic             s1_valid;
  logic             s1_signed;
  logic [WIDTH-1:0] s1_left;
  logic [WIDTH-1:0] s1_right;

  // stage two, full product.
  logic                  s2_valid;
  logic [PROD_WIDTH-1:0] s2_prod;

  logic [PROD_WIDTH-1:0] left_ext;
  logic [PROD_WIDTH-1:0] right_ext;
  logic [PROD_WIDTH-1:0] prod_full;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // valid pipeline
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
      mul_valid <= 1'b0;
    end else begin
      s1_valid  <= start;
      s2_valid  <= s1_valid;
      mul_valid <= s2_valid;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // datapath
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Extending both operands to the product width makes one unsigned
  // multiplier serve both modes; the low PROD_WIDTH bits are exact.
  assign left_ext  = s1_signed ? {{WIDTH{s1_left[WIDTH-1]}}, s1_left}
                               : {{WIDTH{1'b0}}, s1_left};
  assign right_ext = s1_signed ? {{WIDTH{s1_right[WIDTH-1]}}, s1_right}
                               : {{WIDTH{1'b0}}, s1_right};
  assign prod_full = left_ext * right_ext;

  always_ff @(posedge clk) begin
    if (start) begin
      s1_left   <= left;
      s1_right  <= right;
      s1_signed <= is_signed;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      s2_prod <= prod_full;
    end
  end

  // the bits shifted in by an arithmetic shift land above the kept slice,
  // so a plain slice gives the same word in both modes.
  always_ff @(posedge clk) begin
    if (s2_valid) begin
      mul_result <= s2_prod[FRAC_WIDTH +: WIDTH];
    end
  end

endmodule

`default_nettype wire

// File: fp_result_merge.sv
// merge of the multiply and divide results onto one tagged output with a two-slot store
`timescale 1ns/10ps
`default_nettype none

module fp_result_merge import fp_arith_pkg::*; #(
  parameter int WIDTH = DEFAULT_WIDTH
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             mul_valid,
  input  logic [WIDTH-1:0] mul_result,
  input  logic             div_valid,
  input  logic [WIDTH-1:0] div_result,
  output logic [WIDTH-1:0] result,
  output arith_op_e        result_op,
  output logic             done
);

  localparam int SLOTS = 2;
  localparam int CANDS = SLOTS + 2;  // waiting slots, then product, then quotient.

  // waiting results, slot 0 is the oldest.
  logic [SLOTS-1:0] slot_vld;
  logic [WIDTH-1:0] slot_data [SLOTS];
  arith_op_e        slot_op   [SLOTS];

  logic [SLOTS-1:0] slot_vld_next;
  logic [WIDTH-1:0] slot_data_next [SLOTS];
  arith_op_e        slot_op_next   [SLOTS];

  // every result offered this cycle, in age order.
  logic [CANDS-1:0] cand_vld;
  logic [WIDTH-1:0] cand_data [CANDS];
  arith_op_e        cand_op   [CANDS];

  always_comb begin
    for (int i = 0; i < SLOTS; i++) begin
      cand_vld[i]  = slot_vld[i];
      cand_data[i] = slot_data[i];
      cand_op[i]   = slot_op[i];
    end
    cand_vld[SLOTS]    = mul_valid;
    cand_data[SLOTS]   = mul_result;
    cand_op[SLOTS]     = op_mul;
    cand_vld[SLOTS+1]  = div_valid;
    cand_data[SLOTS+1] = div_result;
    cand_op[SLOTS+1]   = op_div;
  end

  // the first valid candidate goes out; the next ones refill the slots.
  always_comb begin : pick
    int taken;
    taken          = 0;
    done           = 1'b0;
    result         = mul_result;
    result_op      = op_mul;
    slot_vld_next  = '0;
    slot_data_next = slot_data;
    slot_op_next   = slot_op;
    for (int i = 0; i < CANDS; i++) begin
      if (cand_vld[i]) begin
        if (taken == 0) begin
          done      = 1'b1;
          result    = cand_data[i];
          result_op = cand_op[i];
        end else if (taken <= SLOTS) begin
          slot_vld_next[taken-1]  = 1'b1;
          slot_data_next[taken-1] = cand_data[i];
          slot_op_next[taken-1]   = cand_op[i];
        end
        taken++;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_vld <= '0;
    end else begin
      slot_vld <= slot_vld_next;
    end
  end

  always_ff @(posedge clk) begin
    slot_data <= slot_data_next;
    slot_op   <= slot_op_next;
  end

endmodule

`default_nettype wire

// File: tb_fp_arith_ref.svh
// reference product and quotient functions and the xorshift generator for the testbench
`ifndef TB_FP_ARITH_REF_SVH
`define TB_FP_ARITH_REF_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reference models
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// double-width product, shifted right by the fraction width, low word kept.
function automatic logic [WIDTH-1:0] ref_mul(
  input logic [WIDTH-1:0] a,
  input logic [WIDTH-1:0] b,
  input logic             sgn
);
  logic signed [2*WIDTH-1:0] ext_a;
  logic signed [2*WIDTH-1:0] ext_b;
  logic signed [2*WIDTH-1:0] prod;
  ext_a = sgn ? {{WIDTH{a[WIDTH-1]}}, a} : {{WIDTH{1'b0}}, a};
  ext_b = sgn ? {{WIDTH{b[WIDTH-1]}}, b} : {{WIDTH{1'b0}}, b};
  prod  = ext_a * ext_b;
  prod  = sgn ? (prod >>> FRAC_WIDTH) : (prod >> FRAC_WIDTH);
  return prod[WIDTH-1:0];
endfunction

// scaled magnitude quotient, sign applied last.
function automatic logic [WIDTH-1:0] ref_div(
  input logic [WIDTH-1:0] a,
  input logic [WIDTH-1:0] b,
  input logic             sgn
);
  logic [WIDTH-1:0]   mag_a;
  logic [WIDTH-1:0]   mag_b;
  logic [WIDTH-1:0]   quo;
  logic [2*WIDTH-1:0] scaled;
  logic               neg;
  mag_a  = (sgn && a[WIDTH-1]) ? -a : a;
  mag_b  = (sgn && b[WIDTH-1]) ? -b : b;
  neg    = sgn && (a[WIDTH-1] != b[WIDTH-1]);
  scaled = {{WIDTH{1'b0}}, mag_a} << FRAC_WIDTH;
  if (mag_b == '0) begin
    quo = '1;  // zero divisor saturates.
  end else begin
    scaled = scaled / {{WIDTH{1'b0}}, mag_b};
    quo    = scaled[WIDTH-1:0];
  end
  return neg ? -quo : quo;
endfunction

// 32-bit xorshift, shifts 13, 17, 5.
function automatic logic [31:0] xorshift32(input logic [31:0] state);
  logic [31:0] x;
  x = state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

`endif

// File: tb_fp_arith_unit.sv
// testbench for the fixed-point arithmetic unit with expected queues, compare process and timeout
`timescale 1ns/10ps
`default_nettype none

module tb_fp_arith_unit import fp_arith_pkg::*; ();

  localparam int WIDTH      = DEFAULT_WIDTH;
  localparam int FRAC_WIDTH = DEFAULT_FRAC_WIDTH;
  localparam int ITERS      = div_iterations(WIDTH, FRAC_WIDTH);
  localparam int MUL_SEEN   = 4;          // drive edge, then the three stages.
  localparam int COLLIDE    = ITERS - 3;  // product that finishes with the quotient.
  localparam int TOTAL_OPS  = 90;
  localparam int TIMEOUT    = TOTAL_OPS * (ITERS + 4) + 500;
  localparam int DRAIN      = ITERS + 16;

  logic             clk;
  logic             rst_n;
  logic             start;
  arith_op_e        op;
  logic             is_signed;
  logic [WIDTH-1:0] left;
  logic [WIDTH-1:0] right;
  logic [WIDTH-1:0] result;
  arith_op_e        result_op;
  logic             done;
  logic             busy;

  `include "tb_fp_arith_ref.svh"

  logic [WIDTH-1:0] mul_exp [$];
  int               mul_cyc [$];
  logic [WIDTH-1:0] div_exp [$];
  logic [WIDTH-1:0] exp_val;
  bit               have_exp;
  logic [31:0]      rng_state;
  bit               check_mul_lat = 1'b0;
  int               cycle = 0;
  int               exp_cyc;
  int               errors = 0;
  int               errors_at_start;
  int               pass_count = 0;
  int               fail_count = 0;
  int               mul_seen;
  int               mul_seen_at_div;

  fp_arith_unit #(
    .WIDTH      (WIDTH),
    .FRAC_WIDTH (FRAC_WIDTH)
  ) i_fp_arith_unit (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  initial begin
    wait (cycle >= TIMEOUT);
    $display("run stopped: no end of test after %0d cycles", cycle);
    $display("Simulation finished: FAIL");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // compare process
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(negedge clk) begin
    if (rst_n && done) begin
      have_exp = 1'b0;
      if (result_op == op_mul) begin
        assert (mul_exp.size() != 0) else begin
          errors++;
          $display("a product came out at %0t with none expected", $time);
        end
        if (mul_exp.size() != 0) begin
          exp_val  = mul_exp.pop_front();
          exp_cyc  = mul_cyc.pop_front();
          have_exp = 1'b1;
          mul_seen++;
          assert (!check_mul_lat || cycle - exp_cyc == MUL_SEEN) else begin
            errors++;
            $display("Error at %0t: done latency expected %0d, got %0d",
                     $time, MUL_SEEN, cycle - exp_cyc);
          end
        end
      end else begin
        assert (div_exp.size() != 0) else begin
          errors++;
          $display("a quotient came out at %0t with none expected", $time);
        end
        mul_seen_at_div = mul_seen;
        if (div_exp.size() != 0) begin
          exp_val  = div_exp.pop_front();
          have_exp = 1'b1;
        end
      end
      if (have_exp) begin
        assert (result == exp_val) else begin
          errors++;
          $display("Error at %0t: result expected %h, got %h", $time, exp_val, result);
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic next_random(output logic [WIDTH-1:0] value);
    rng_state = xorshift32(rng_state);
    value     = rng_state;
  endtask

  task automatic drive_op(input arith_op_e kind, input logic sgn,
                          input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b,
                          input bit expected);
    @(posedge clk);
    start     <= 1'b1;
    op        <= kind;
    is_signed <= sgn;
    left      <= a;
    right     <= b;
    if (expected && kind == op_mul) begin
      mul_exp.push_back(ref_mul(a, b, sgn));
      mul_cyc.push_back(cycle);
    end else if (expected) begin
      div_exp.push_back(ref_div(a, b, sgn));
    end
  endtask

  task automatic drive_idle();
    @(posedge clk);
    start <= 1'b0;
  endtask

  // one divide, with the length of its busy window checked.
  task automatic run_div(input logic sgn, input logic [WIDTH-1:0] a,
                         input logic [WIDTH-1:0] b);
    int len;
    len = 0;
    drive_op(op_div, sgn, a, b, 1'b1);
    drive_idle();
    @(negedge clk);
    while (busy) begin
      len++;
      @(negedge clk);
    end
    assert (len == ITERS) else begin
      errors++;
      $display("Error at %0t: busy cycles expected %0d, got %0d", $time, ITERS, len);
    end
  endtask

  task automatic begin_test();
    errors_at_start = errors;
    mul_seen        = 0;
    mul_seen_at_div = -1;
  endtask

  task automatic finish_test(input string name);
    int waited;
    waited = 0;
    while ((mul_exp.size() != 0 || div_exp.size() != 0 || busy) && waited < DRAIN) begin
      @(negedge clk);
      waited++;
    end
    repeat (3) @(negedge clk);
    assert (mul_exp.size() == 0 && div_exp.size() == 0) else begin
      errors++;
      $display("%0d products and %0d quotients never came out",
               mul_exp.size(), div_exp.size());
    end
    mul_exp.delete();
    mul_cyc.delete();
    div_exp.delete();
    if (errors == errors_at_start) begin
      pass_count++;
      $display("test %s: passed", name);
    end else begin
      fail_count++;
      $display("test %s: failed with %0d errors", name, errors - errors_at_start);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin : stimulus
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    rng_state = 32'd6;
    rst_n     = 1'b0;
    start     = 1'b0;
    op        = op_mul;
    is_signed = 1'b0;
    left      = '0;
    right     = '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    begin_test();
    repeat (4) begin
      @(negedge clk);
      assert (!done && !busy) else begin
        errors++;
        $display("done or busy is high at %0t before any start", $time);
      end
    end
    finish_test("idle after reset");

    begin_test();
    check_mul_lat = 1'b1;
    drive_op(op_mul, 1'b1, 32'h0001_8000, 32'hfffe_0000, 1'b1);  // 1.5 times -2.0.
    for (int i = 0; i < 15; i++) begin
      next_random(a);
      next_random(b);
      drive_op(op_mul, i[0], a, b, 1'b1);
    end
    drive_idle();
    finish_test("back-to-back multiplies");
    check_mul_lat = 1'b0;

    begin_test();
    run_div(1'b0, 32'h0003_0000, 32'h0002_0000);  // 3.0 over 2.0.
    for (int i = 0; i < 11; i++) begin
      next_random(a);
      next_random(b);
      if (i >= 3) begin
        a[WIDTH-1] = i[0];  // every sign pair twice.
        b[WIDTH-1] = i[1];
      end
      run_div(i >= 3, a, b);
    end
    run_div(1'b0, 32'h0004_0000, '0);
    run_div(1'b1, 32'h0004_0000, '0);
    run_div(1'b1, 32'hfffc_0000, '0);
    finish_test("divides");

    begin_test();
    drive_op(op_div, 1'b0, 32'h0009_0000, 32'h0003_0000, 1'b1);
    drive_idle();
    repeat (4) @(negedge clk);
    assert (busy) else begin
      errors++;
      $display("divider was not busy at %0t", $time);
    end
    drive_op(op_div, 1'b1, 32'h0001_0000, 32'h0007_0000, 1'b0);  // lost while busy.
    drive_idle();
    while (busy) @(negedge clk);
    run_div(1'b1, 32'hfff8_0000, 32'h0002_0000);
    finish_test("divide start while busy");

    begin_test();
    next_random(a);
    next_random(b);
    drive_op(op_div, 1'b1, a, b, 1'b1);
    for (int i = 0; i < ITERS + 2; i++) begin
      next_random(a);
      next_random(b);
      drive_op(op_mul, i[0], a, b, 1'b1);
    end
    drive_idle();
    repeat (4) @(negedge clk);
    assert (mul_seen_at_div == COLLIDE + 1) else begin
      errors++;
      $display("the quotient did not follow the colliding product");
    end
    finish_test("multiplies during a divide");

    $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (errors == 0 && fail_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
